// ==== rtl/arch_map.sv ====
`timescale 1ns/1ps

module arch_map import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      retire_valid,
  input  arch_reg_t retire_arch,
  input  pr_t       retire_pr,
  output map_t      arch_table
);

  map_t arch_q;  // committed map

  // includes the retirement at this edge, so a flush
  // alongside a retirement restores the up to date map
  always_comb begin
    arch_table = arch_q;
    if (retire_valid) begin
      arch_table[retire_arch] = retire_pr;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      arch_q <= identity_map();
    end else if (retire_valid) begin
      arch_q[retire_arch] <= retire_pr;
    end
  end

endmodule

// ==== rtl/free_list.sv ====
`timescale 1ns/1ps

module free_list import rename_pkg::*; #(
  parameter int NUM_PR = 64
) (
  input  logic clock,
  input  logic reset,
  input  logic alloc,
  input  logic free_valid,
  input  pr_t  free_pr,
  input  logic flush,
  output pr_t  fl_pr,
  output logic fl_empty
);

  localparam int FL_DEPTH = NUM_PR - NUM_ARCH;
  localparam int PTR_W    = (FL_DEPTH > 1) ? $clog2(FL_DEPTH) : 1;
  localparam int CNT_W    = $clog2(FL_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;

  pr_t              fl_mem [FL_DEPTH];
  ptr_t             head;
  ptr_t             tail;
  ptr_t             retire_head;  // head as of the last retirement
  logic [CNT_W-1:0] free_count;

  function automatic ptr_t wrap_inc(input ptr_t p);
    return (p == ptr_t'(FL_DEPTH - 1)) ? '0 : p + ptr_t'(1);
  endfunction

  assign fl_pr    = fl_mem[head];
  assign fl_empty = (free_count == '0);

  ////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      head        <= '0;
      tail        <= '0;
      retire_head <= '0;
      free_count  <= CNT_W'(FL_DEPTH);  // starts full
    end else begin
      if (free_valid) begin
        tail        <= wrap_inc(tail);
        retire_head <= wrap_inc(retire_head);  // same order as alloc
      end
      if (flush) begin
        // every in-flight PR comes back
        head       <= free_valid ? wrap_inc(retire_head) : retire_head;
        free_count <= CNT_W'(FL_DEPTH);
      end else begin
        if (alloc) begin
          head <= wrap_inc(head);
        end
        free_count <= free_count + CNT_W'(free_valid) - CNT_W'(alloc);
      end
    end
  end

  // storage, filled with NUM_ARCH.. at reset
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < FL_DEPTH; i++) begin
        fl_mem[i] <= pr_t'(NUM_ARCH + i);
      end
    end else if (free_valid) begin
      fl_mem[tail] <= free_pr;
    end
  end

endmodule

// ==== rtl/map_table.sv ====
`timescale 1ns/1ps

module map_table import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      rename_en,
  input  arch_reg_t dest,
  input  pr_t       new_pr,
  input  arch_reg_t src1,
  input  arch_reg_t src2,
  input  logic      complete_valid,
  input  pr_t       complete_pr,
  input  logic      flush,
  input  map_t      arch_table,
  output pr_t       src1_pr,
  output pr_t       src2_pr,
  output pr_t       old_pr,
  output logic      src1_ready,
  output logic      src2_ready
);

  map_t                spec_map;
  logic [PR_SLOTS-1:0] pr_ready;

  // ready bit with same-cycle completion bypass
  function automatic logic ready_of(
    input pr_t                 pr,
    input logic [PR_SLOTS-1:0] ready_bits,
    input logic                cmp_valid,
    input pr_t                 cmp_pr
  );
    return ready_bits[pr] || (cmp_valid && (cmp_pr == pr));
  endfunction

  ////////////////////////////////////////
  // lookups
  ////////////////////////////////////////
  // reads see the map before this cycle's rename
  always_comb begin
    src1_pr    = spec_map[src1];
    src2_pr    = spec_map[src2];
    old_pr     = spec_map[dest];  // superseded mapping, goes to the ROB
    src1_ready = ready_of(spec_map[src1], pr_ready, complete_valid, complete_pr);
    src2_ready = ready_of(spec_map[src2], pr_ready, complete_valid, complete_pr);
  end

  ////////////////////////////////////////
  // updates
  ////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      spec_map <= identity_map();
      pr_ready <= '1;
    end else if (flush) begin
      // committed state only, so everything is ready
      spec_map <= arch_table;
      pr_ready <= '1;
    end else begin
      if (complete_valid) begin
        pr_ready[complete_pr] <= 1'b1;
      end
      // new_pr is free, never the one completing
      if (rename_en) begin
        spec_map[dest]   <= new_pr;
        pr_ready[new_pr] <= 1'b0;
      end
    end
  end

endmodule

// ==== rtl/rename_core.sv ====
`timescale 1ns/1ps

module rename_core import rename_pkg::*; #(
  parameter int NUM_PR  = 64,
  parameter int NUM_ROB = 16
) (
  input  logic      clock,
  input  logic      reset,
  // dispatch
  input  logic      dispatch_valid,
  input  arch_reg_t dispatch_dest,
  input  arch_reg_t dispatch_src1,
  input  arch_reg_t dispatch_src2,
  output logic      dispatch_ready,
  output rob_idx_t  dispatch_rob_idx,
  output pr_t       dispatch_pr,
  output pr_t       dispatch_old_pr,
  output pr_t       src1_pr,
  output logic      src1_ready,
  output pr_t       src2_pr,
  output logic      src2_ready,
  // completion
  input  logic      complete_valid,
  input  rob_idx_t  complete_rob_idx,
  // retirement
  output logic      retire_valid,
  output arch_reg_t retire_arch,
  output pr_t       retire_pr,
  output pr_t       retire_old_pr,
  input  logic      flush
);

  logic accept;
  logic rob_full;
  logic fl_empty;
  pr_t  fl_pr;
  pr_t  old_pr;
  pr_t  complete_pr;
  map_t arch_table;

  assign dispatch_ready  = !rob_full && !fl_empty;
  assign accept          = dispatch_valid && dispatch_ready && !flush;  // flush wins
  assign dispatch_pr     = fl_pr;
  assign dispatch_old_pr = old_pr;

  ////////////////////////////////////////
  // blocks
  ////////////////////////////////////////
  free_list #(.NUM_PR(NUM_PR)) free_list0 (
    .clock      (clock),
    .reset      (reset),
    .alloc      (accept),
    .free_valid (retire_valid),
    .free_pr    (retire_old_pr),  // superseded PR goes back
    .flush      (flush),
    .fl_pr      (fl_pr),
    .fl_empty   (fl_empty)
  );

  map_table map_table0 (
    .clock          (clock),
    .reset          (reset),
    .rename_en      (accept),
    .dest           (dispatch_dest),
    .new_pr         (fl_pr),
    .src1           (dispatch_src1),
    .src2           (dispatch_src2),
    .complete_valid (complete_valid),
    .complete_pr    (complete_pr),
    .flush          (flush),
    .arch_table     (arch_table),
    .src1_pr        (src1_pr),
    .src2_pr        (src2_pr),
    .old_pr         (old_pr),
    .src1_ready     (src1_ready),
    .src2_ready     (src2_ready)
  );

  arch_map arch_map0 (
    .clock        (clock),
    .reset        (reset),
    .retire_valid (retire_valid),
    .retire_arch  (retire_arch),
    .retire_pr    (retire_pr),
    .arch_table   (arch_table)
  );

  rob #(.NUM_ROB(NUM_ROB)) rob0 (
    .clock            (clock),
    .reset            (reset),
    .alloc            (accept),
    .dest             (dispatch_dest),
    .new_pr           (fl_pr),
    .old_pr           (old_pr),
    .complete_valid   (complete_valid),
    .complete_rob_idx (complete_rob_idx),
    .flush            (flush),
    .alloc_idx        (dispatch_rob_idx),
    .rob_full         (rob_full),
    .complete_pr      (complete_pr),
    .retire_valid     (retire_valid),
    .retire_arch      (retire_arch),
    .retire_pr        (retire_pr),
    .retire_old_pr    (retire_old_pr)
  );

endmodule

// ==== rtl/rename_pkg.sv ====
package rename_pkg;

  localparam int NUM_ARCH = 32;  // fixed by the ISA
  localparam int PR_W     = 6;
  localparam int ROB_W    = 4;
  localparam int PR_SLOTS = 1 << PR_W;  // largest physical file a tag can name

  typedef logic [4:0]       arch_reg_t;
  typedef logic [PR_W-1:0]  pr_t;
  typedef logic [ROB_W-1:0] rob_idx_t;

  // whole map, arch reg r in slice r
  typedef pr_t [NUM_ARCH-1:0] map_t;

  typedef enum logic [1:0] {
    ROB_EMPTY,
    ROB_PARTIAL,
    ROB_FULL
  } rob_state_t;

  // reset map: arch reg r lives in phys reg r
  function automatic map_t identity_map();
    map_t m;
    for (int r = 0; r < NUM_ARCH; r++) begin
      m[r] = pr_t'(r);
    end
    return m;
  endfunction

endpackage

// ==== rtl/rob.sv ====
`timescale 1ns/1ps

module rob import rename_pkg::*; #(
  parameter int NUM_ROB = 16
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      alloc,
  input  arch_reg_t dest,
  input  pr_t       new_pr,
  input  pr_t       old_pr,
  input  logic      complete_valid,
  input  rob_idx_t  complete_rob_idx,
  input  logic      flush,
  output rob_idx_t  alloc_idx,
  output logic      rob_full,
  output pr_t       complete_pr,
  output logic      retire_valid,
  output arch_reg_t retire_arch,
  output pr_t       retire_pr,
  output pr_t       retire_old_pr
);

  localparam int IDX_W = (NUM_ROB > 1) ? $clog2(NUM_ROB) : 1;

  typedef logic [IDX_W-1:0] ptr_t;

  // entry payload
  arch_reg_t dest_q   [NUM_ROB];
  pr_t       new_pr_q [NUM_ROB];
  pr_t       old_pr_q [NUM_ROB];

  logic [NUM_ROB-1:0] done_q;
  ptr_t               head;
  ptr_t               tail;
  ptr_t               head_n;
  ptr_t               tail_n;
  ptr_t               cmp_idx;
  rob_state_t         state;
  rob_state_t         state_n;

  function automatic ptr_t wrap_inc(input ptr_t p);
    return (p == ptr_t'(NUM_ROB - 1)) ? '0 : p + ptr_t'(1);
  endfunction

  assign cmp_idx     = ptr_t'(complete_rob_idx);
  assign alloc_idx   = rob_idx_t'(tail);
  assign rob_full    = (state == ROB_FULL);
  assign complete_pr = new_pr_q[cmp_idx];

  ////////////////////////////////////////
  // retirement, one per cycle from the head
  ////////////////////////////////////////
  assign retire_valid  = (state != ROB_EMPTY) && done_q[head];
  assign retire_arch   = dest_q[head];
  assign retire_pr     = new_pr_q[head];
  assign retire_old_pr = old_pr_q[head];

  ////////////////////////////////////////
  // occupancy FSM
  ////////////////////////////////////////
  always_comb begin
    head_n = retire_valid ? wrap_inc(head) : head;
    tail_n = alloc ? wrap_inc(tail) : tail;
    if (flush) begin
      tail_n  = head_n;  // squash all, head retirement still counts
      state_n = ROB_EMPTY;
    end else if (head_n != tail_n) begin
      state_n = ROB_PARTIAL;
    end else if (alloc && !retire_valid) begin
      state_n = ROB_FULL;
    end else if (retire_valid && !alloc) begin
      state_n = ROB_EMPTY;
    end else begin
      state_n = state;  // alloc and retire together
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head   <= '0;
      tail   <= '0;
      state  <= ROB_EMPTY;
      done_q <= '0;
    end else begin
      head  <= head_n;
      tail  <= tail_n;
      state <= state_n;
      if (complete_valid && !flush) begin
        done_q[cmp_idx] <= 1'b1;
      end
      if (alloc) begin
        done_q[tail] <= 1'b0;  // fresh entry
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      dest_q[tail]   <= dest;
      new_pr_q[tail] <= new_pr;
      old_pr_q[tail] <= old_pr;
    end
  end

endmodule

// ==== sim.f ====
rtl/rename_pkg.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/arch_map.sv
rtl/rob.sv
rtl/rename_core.sv
sim/rename_props.sv
sim/rename_tb.sv

// ==== sim/rename_props.sv ====
`timescale 1ns/1ps

module rename_props #(
  parameter int NUM_ROB = 16
) (
  input logic clock,
  input logic reset,
  input logic flush,
  input logic dispatch_valid,
  input logic dispatch_ready,
  input logic retire_valid
);

  int occupancy;  // ROB entries, counted from the handshake
  int fail_count = 0;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      occupancy <= 0;
    end else begin
      occupancy <= occupancy + int'(dispatch_valid && dispatch_ready) - int'(retire_valid);
    end
  end

  ////////////////////////////////////////
  // handshake and recovery rules
  ////////////////////////////////////////
  a_full_blocks_dispatch: assert property (
    @(posedge clock) disable iff (reset) (occupancy == NUM_ROB) |-> !dispatch_ready
  ) else begin
    fail_count++;
    $error("dispatch_ready high while the ROB is full");
  end

  // ROB empty one cycle after flush
  a_flush_clears_retire: assert property (
    @(posedge clock) disable iff (reset) flush |=> !retire_valid
  ) else begin
    fail_count++;
    $error("retire_valid high in the cycle after a flush");
  end

  a_reset_clears_retire: assert property (
    @(posedge clock) reset |=> !retire_valid
  ) else begin
    fail_count++;
    $error("retire_valid high during reset");
  end

endmodule

bind rename_core rename_props #(.NUM_ROB(NUM_ROB)) props0 (
  .clock          (clock),
  .reset          (reset),
  .flush          (flush),
  .dispatch_valid (dispatch_valid),
  .dispatch_ready (dispatch_ready),
  .retire_valid   (retire_valid)
);

// ==== sim/rename_tb.sv ====
`timescale 1ns/1ps

module rename_tb import rename_pkg::*;;

  localparam int NUM_PR         = 64;
  localparam int NUM_ROB        = 16;
  localparam int RESET_CYCLES   = 16;
  localparam int DIRECTED       = 20;    // fills the ROB with completions held back
  localparam int RANDOM_CYCLES  = 2000;
  localparam int TIMEOUT_CYCLES = 3000;  // reset + directed + random, with margin

  typedef struct packed {
    logic      dispatch_ready;
    rob_idx_t  rob_idx;
    pr_t       pr;
    pr_t       old_pr;
    pr_t       src1_pr;
    logic      src1_ready;
    pr_t       src2_pr;
    logic      src2_ready;
    logic      retire_valid;
    arch_reg_t retire_arch;
    pr_t       retire_pr;
    pr_t       retire_old_pr;
    pr_t       cmp_pr;
  } exp_t;

  typedef struct packed {
    arch_reg_t dest;
    pr_t       new_pr;
    pr_t       old_pr;
    rob_idx_t  idx;
    logic      done;
  } inst_t;

  logic clock;
  logic reset;
  logic dispatch_valid;
  arch_reg_t dispatch_dest;
  arch_reg_t dispatch_src1;
  arch_reg_t dispatch_src2;
  logic dispatch_ready;
  rob_idx_t dispatch_rob_idx;
  pr_t dispatch_pr;
  pr_t dispatch_old_pr;
  pr_t src1_pr;
  logic src1_ready;
  pr_t src2_pr;
  logic src2_ready;
  logic complete_valid;
  rob_idx_t complete_rob_idx;
  logic retire_valid;
  arch_reg_t retire_arch;
  pr_t retire_pr;
  pr_t retire_old_pr;
  logic flush;

  // reference model state
  pr_t                 spec_m [NUM_ARCH];
  pr_t                 arch_m [NUM_ARCH];
  logic [PR_SLOTS-1:0] ready_m;
  pr_t                 free_q [$];
  inst_t               inflight [$];  // program order, oldest first
  int                  rob_head;
  int                  rob_tail;

  logic run_active;
  int   cycle_count;

  rename_core #(.NUM_PR(NUM_PR), .NUM_ROB(NUM_ROB)) dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic pr_t pr_at_index(input rob_idx_t idx);
    foreach (inflight[i]) begin
      if (inflight[i].idx == idx) return inflight[i].new_pr;
    end
    return '0;
  endfunction

  function automatic exp_t expected_outputs();
    exp_t e;
    e.dispatch_ready = (inflight.size() < NUM_ROB) && (free_q.size() != 0);
    e.rob_idx        = rob_idx_t'(rob_tail);
    e.pr             = (free_q.size() != 0) ? free_q[0] : '0;
    e.old_pr         = spec_m[dispatch_dest];
    e.src1_pr        = spec_m[dispatch_src1];
    e.src2_pr        = spec_m[dispatch_src2];
    e.cmp_pr         = pr_at_index(complete_rob_idx);
    e.src1_ready     = ready_m[e.src1_pr] || (complete_valid && e.cmp_pr == e.src1_pr);
    e.src2_ready     = ready_m[e.src2_pr] || (complete_valid && e.cmp_pr == e.src2_pr);
    e.retire_valid   = (inflight.size() != 0) && inflight[0].done;
    e.retire_arch    = (inflight.size() != 0) ? inflight[0].dest : '0;
    e.retire_pr      = (inflight.size() != 0) ? inflight[0].new_pr : '0;
    e.retire_old_pr  = (inflight.size() != 0) ? inflight[0].old_pr : '0;
    return e;
  endfunction

  // state after the coming edge
  function automatic void update_model(input exp_t e);
    inst_t ent;
    if (e.retire_valid) begin
      ent = inflight.pop_front();
      arch_m[ent.dest] = ent.new_pr;
      free_q.push_back(ent.old_pr);
      rob_head = (rob_head + 1) % NUM_ROB;
    end
    if (flush) begin
      for (int i = inflight.size() - 1; i >= 0; i--) begin
        free_q.push_front(inflight[i].new_pr);  // unretired PRs go back in order
      end
      inflight.delete();
      spec_m   = arch_m;
      ready_m  = '1;
      rob_tail = rob_head;
    end else begin
      if (complete_valid) begin
        foreach (inflight[i]) begin
          if (inflight[i].idx == complete_rob_idx) begin
            ent = inflight[i];
            ent.done = 1'b1;
            inflight[i] = ent;
          end
        end
        ready_m[e.cmp_pr] = 1'b1;
      end
      if (dispatch_valid && e.dispatch_ready) begin
        ent.dest   = dispatch_dest;
        ent.new_pr = free_q.pop_front();
        ent.old_pr = spec_m[dispatch_dest];
        ent.idx    = rob_idx_t'(rob_tail);
        ent.done   = 1'b0;
        inflight.push_back(ent);
        spec_m[dispatch_dest] = ent.new_pr;
        ready_m[ent.new_pr]   = 1'b0;
        rob_tail = (rob_tail + 1) % NUM_ROB;
      end
    end
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  ////////////////////////////////////////
  // compare, outputs settled mid cycle
  ////////////////////////////////////////
  always @(negedge clock) begin : compare
    exp_t e;
    if (run_active) begin
      e = expected_outputs();
      check("dispatch_ready", dispatch_ready, e.dispatch_ready);
      check("dispatch_rob_idx", dispatch_rob_idx, e.rob_idx);
      if (free_q.size() != 0) check("dispatch_pr", dispatch_pr, e.pr);
      check("dispatch_old_pr", dispatch_old_pr, e.old_pr);
      check("src1_pr", src1_pr, e.src1_pr);
      check("src1_ready", src1_ready, e.src1_ready);
      check("src2_pr", src2_pr, e.src2_pr);
      check("src2_ready", src2_ready, e.src2_ready);
      check("retire_valid", retire_valid, e.retire_valid);
      if (e.retire_valid) begin
        check("retire_arch", retire_arch, e.retire_arch);
        check("retire_pr", retire_pr, e.retire_pr);
        check("retire_old_pr", retire_old_pr, e.retire_old_pr);
      end
      update_model(e);
    end
  end

  always @(dut0.props0.fail_count) begin
    if (dut0.props0.fail_count != 0) begin
      $display("A concurrent assertion on the DUT failed");
      $display("Simulation FAILED");
      $fatal(1, "assertion failure");
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  task automatic drive_cycle(input bit directed);
    int pick;
    dispatch_valid   = directed ? 1'b1 : (($urandom % 4) != 0);
    dispatch_dest    = arch_reg_t'($urandom % NUM_ARCH);
    dispatch_src1    = arch_reg_t'($urandom % NUM_ARCH);
    dispatch_src2    = arch_reg_t'($urandom % NUM_ARCH);
    complete_valid   = 1'b0;
    complete_rob_idx = '0;
    flush            = directed ? 1'b0 : (($urandom % 100) == 0);
    if (!directed && inflight.size() != 0 && ($urandom % 2) == 1) begin
      pick             = $urandom % inflight.size();
      complete_valid   = 1'b1;
      complete_rob_idx = inflight[pick].idx;
    end
  endtask

  initial begin
    void'($urandom(32'had91));
    reset            = 1'b1;
    dispatch_valid   = 1'b0;
    dispatch_dest    = '0;
    dispatch_src1    = '0;
    dispatch_src2    = '0;
    complete_valid   = 1'b0;
    complete_rob_idx = '0;
    flush            = 1'b0;
    run_active       = 1'b0;
    cycle_count      = 0;
    for (int r = 0; r < NUM_ARCH; r++) begin
      spec_m[r] = pr_t'(r);
      arch_m[r] = pr_t'(r);
    end
    for (int p = NUM_ARCH; p < NUM_PR; p++) free_q.push_back(pr_t'(p));
    ready_m  = '1;
    rob_head = 0;
    rob_tail = 0;

    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset      = 1'b0;
    run_active = 1'b1;
    for (int cyc = 0; cyc < DIRECTED + RANDOM_CYCLES; cyc++) begin
      drive_cycle(cyc < DIRECTED);
      @(posedge clock);
      #1;
    end
    run_active = 1'b0;

    $display("Simulation PASSED");
    $finish;
  end

endmodule
